//--- Bender.yml
package:
  name: controller_standby_i3c

sources:
  - files:
      - hdl/i3c_target_pkg.sv
      - hdl/bus_monitor.sv
      - hdl/i3c_target_fsm.sv
      - hdl/target_queue_flow.sv
      - hdl/controller_standby_i3c.sv
  - target: simulation
    files:
      - bench/clk_rst_gen.sv
      - bench/tb_controller_standby_i3c.sv

//--- bench/clk_rst_gen.sv
// Testbench clock and reset source, 10 ns clock with reset held for the first three cycles
`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/tb_controller_standby_i3c.sv
// Testbench for the I3C standby target that bit-bangs the host side and models the three queues
`timescale 1ns/1ps
`default_nettype none

module tb_controller_standby_i3c;

  localparam logic [6:0]  StaticAddr = 7'h22;
  localparam logic [6:0]  DynAddr    = 7'h5A;
  localparam int unsigned QueueWidth = 32;
  localparam int          SclPhase   = 8;
  // Header and data bits of all transfers plus three bits for each START and STOP
  localparam int          TransferBits = 366;
  localparam int          WatchdogNs   = TransferBits * 2 * SclPhase * 10 + 40000;

  logic clk;
  logic reset_i;
  logic enable_i;
  logic scl;
  logic sda_host;
  logic sda_o;
  logic sda_bus;
  logic rx_queue_wvalid_o;
  logic rx_queue_wready_i;
  logic [QueueWidth-1:0] rx_queue_wdata_o;
  logic rx_desc_wvalid_o;
  logic rx_desc_wready_i;
  logic [31:0] rx_desc_wdata_o;
  logic tx_queue_rvalid_i;
  logic tx_queue_rready_o;
  logic [QueueWidth-1:0] tx_queue_rdata_i;

  integer seed;
  int value_errors;
  int proto_errors;
  int timeout_errors;
  logic bus_started;
  logic hold_wready;
  logic tx_taken;
  int tx_pos;
  int pool_pos;
  int last_base;
  int bad_tbit;
  int read_count;
  logic [7:0] pool [64];
  logic [31:0] rx_words [$];
  logic [31:0] rx_descs [$];
  logic [31:0] exp_words [$];
  logic [31:0] tx_words [$];

  // Open-drain SDA
  assign sda_bus = sda_host & sda_o;

  clk_rst_gen i_clk_rst_gen (
    .clk_o  (clk),
    .reset_o(reset_i)
  );

  controller_standby_i3c #(
    .StaticAddr(StaticAddr),
    .DynAddr   (DynAddr),
    .QueueWidth(QueueWidth)
  ) i_controller_standby_i3c (
    .clk_i            (clk),
    .reset_i          (reset_i),
    .enable_i         (enable_i),
    .scl_i            (scl),
    .sda_i            (sda_bus),
    .sda_o            (sda_o),
    .rx_queue_wvalid_o(rx_queue_wvalid_o),
    .rx_queue_wready_i(rx_queue_wready_i),
    .rx_queue_wdata_o (rx_queue_wdata_o),
    .rx_desc_wvalid_o (rx_desc_wvalid_o),
    .rx_desc_wready_i (rx_desc_wready_i),
    .rx_desc_wdata_o  (rx_desc_wdata_o),
    .tx_queue_rvalid_i(tx_queue_rvalid_i),
    .tx_queue_rready_o(tx_queue_rready_o),
    .tx_queue_rdata_i (tx_queue_rdata_i)
  );

  // Queue models drive ready and TX data on the falling edge
  always @(negedge clk) begin
    if (reset_i) begin
      rx_queue_wready_i <= 1'b0;
      rx_desc_wready_i  <= 1'b0;
    end else begin
      rx_queue_wready_i <= !hold_wready && ($random(seed) & 1) != 0;
      rx_desc_wready_i  <= $random(seed);
    end
    if (tx_taken) begin
      tx_pos = tx_pos + 1;
    end
    tx_queue_rvalid_i <= tx_pos < tx_words.size();
    tx_queue_rdata_i  <= (tx_pos < tx_words.size()) ? tx_words[tx_pos] : '0;
  end

  always @(posedge clk) begin
    tx_taken <= !reset_i && tx_queue_rvalid_i && tx_queue_rready_o;
    if (!reset_i && rx_queue_wvalid_o && rx_queue_wready_i) begin
      rx_words.push_back(rx_queue_wdata_o);
    end
    if (!reset_i && rx_desc_wvalid_o && rx_desc_wready_i) begin
      rx_descs.push_back(rx_desc_wdata_o);
    end
  end

  idle_after_reset_a : assert property (
    @(posedge clk) disable iff (reset_i)
    !bus_started |-> sda_o && !rx_queue_wvalid_o && !rx_desc_wvalid_o && !tx_queue_rready_o
  ) else begin
    proto_errors++;
    $display("DUT output left its idle value before the first transfer at %0t ns", $time);
  end

  rx_word_hold_a : assert property (
    @(posedge clk) disable iff (reset_i)
    rx_queue_wvalid_o && !rx_queue_wready_i |=> rx_queue_wvalid_o && $stable(rx_queue_wdata_o)
  ) else begin
    proto_errors++;
    $display("RX word dropped or changed before it was accepted at %0t ns", $time);
  end

  rx_desc_hold_a : assert property (
    @(posedge clk) disable iff (reset_i)
    rx_desc_wvalid_o && !rx_desc_wready_i |=> rx_desc_wvalid_o && $stable(rx_desc_wdata_o)
  ) else begin
    proto_errors++;
    $display("RX descriptor dropped or changed before it was accepted at %0t ns", $time);
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic drive_bit(input logic b, output logic s);
    sda_host = b;
    wait_cycles(SclPhase / 2);
    scl = 1'b1;
    wait_cycles(SclPhase);
    s = sda_bus;
    scl = 1'b0;
    wait_cycles(SclPhase / 2);
  endtask

  task automatic bus_start();
    bus_started = 1'b1;
    wait_cycles(SclPhase);
    sda_host = 1'b0;
    wait_cycles(SclPhase);
    scl = 1'b0;
    wait_cycles(SclPhase / 2);
  endtask

  task automatic bus_stop();
    sda_host = 1'b0;
    wait_cycles(SclPhase / 2);
    scl = 1'b1;
    wait_cycles(SclPhase);
    sda_host = 1'b1;
    wait_cycles(SclPhase);
  endtask

  task automatic send_header(input logic [6:0] addr, input logic rnw, output logic ack);
    logic [7:0] hdr;
    logic s;
    hdr = {addr, rnw};
    for (int i = 7; i >= 0; i--) begin
      drive_bit(hdr[i], s);
    end
    drive_bit(1'b1, ack);
  endtask

  // Bytes come from the pool and the T-bit is odd parity unless bad_tbit picks the byte
  task automatic write_xfer(input logic [6:0] addr, input int n, input logic exp_ack);
    logic ack;
    logic s;
    logic [7:0] b;
    bus_start();
    send_header(addr, 1'b0, ack);
    check_value("sda at ACK", ack, exp_ack ? 0 : 1);
    last_base = pool_pos;
    if (!ack) begin
      for (int i = 0; i < n; i++) begin
        b = pool[pool_pos + i];
        for (int j = 7; j >= 0; j--) begin
          drive_bit(b[j], s);
        end
        drive_bit((~^b) ^ (i == bad_tbit), s);
      end
      pool_pos = pool_pos + n;
    end
    bus_stop();
  endtask

  task automatic read_xfer(input logic [6:0] addr);
    logic ack;
    logic s;
    logic t;
    logic [7:0] b;
    logic [31:0] w;
    int total;
    int k;
    total = tx_words.size() * 4;
    k = 0;
    bus_start();
    send_header(addr, 1'b1, ack);
    check_value("sda at ACK", ack, 0);
    t = !ack;
    while (t && k <= total) begin
      for (int j = 0; j < 8; j++) begin
        drive_bit(1'b1, s);
        b = {b[6:0], s};
      end
      w = (k < total) ? (tx_words[k / 4] >> (8 * (k % 4))) : 32'hFF;
      check_value("read byte", b, w[7:0]);
      drive_bit(1'b1, t);
      check_value("read T-bit", t, k < total - 1);
      k++;
    end
    read_count = k;
    bus_stop();
  endtask

  task automatic expect_words(input int base, input int n);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      w[8 * (i % 4) +: 8] = pool[base + i];
      if (i % 4 == 3 || i == n - 1) begin
        exp_words.push_back(w);
        w = '0;
      end
    end
  endtask

  function automatic logic [31:0] make_desc(input int count, input logic par,
                                            input logic ovf, input logic dyn,
                                            input logic rd);
    logic [31:0] d;
    d = '0;
    d[i3c_target_pkg::DESC_COUNT_LSB +: i3c_target_pkg::DESC_COUNT_W] = count;
    d[i3c_target_pkg::DESC_PARITY_ERR_BIT] = par;
    d[i3c_target_pkg::DESC_OVERFLOW_BIT]   = ovf;
    d[i3c_target_pkg::DESC_DYN_HIT_BIT]    = dyn;
    d[i3c_target_pkg::DESC_READ_BIT]       = rd;
    return d;
  endfunction

  task automatic check_rx(input logic [31:0] exp_desc);
    int n;
    n = 0;
    while (rx_descs.size() == 0 && n < 500) begin
      wait_cycles(1);
      n++;
    end
    if (rx_descs.size() == 0) begin
      timeout_errors++;
      $display("timeout: no RX descriptor written after the transfer at %0t ns", $time);
    end else begin
      check_value("RX word count", rx_words.size(), exp_words.size());
      for (int i = 0; i < exp_words.size() && i < rx_words.size(); i++) begin
        check_value("rx_queue_wdata_o", rx_words[i], exp_words[i]);
      end
      check_value("rx_desc_wdata_o", rx_descs[0], exp_desc);
    end
    rx_words.delete();
    rx_descs.delete();
    exp_words.delete();
  endtask

  // Nothing may reach either RX queue
  task automatic check_quiet();
    wait_cycles(60);
    check_value("RX word count", rx_words.size(), 0);
    check_value("RX descriptor count", rx_descs.size(), 0);
  endtask

  initial begin
    seed = 32'hf296_94b9;
    enable_i = 1'b1;
    scl = 1'b1;
    sda_host = 1'b1;
    tx_queue_rvalid_i = 1'b0;
    tx_queue_rdata_i = '0;
    rx_queue_wready_i = 1'b0;
    rx_desc_wready_i = 1'b0;
    bus_started = 1'b0;
    hold_wready = 1'b0;
    tx_taken = 1'b0;
    tx_pos = 0;
    pool_pos = 0;
    bad_tbit = -1;
    value_errors = 0;
    proto_errors = 0;
    timeout_errors = 0;
    for (int i = 0; i < 64; i++) begin
      pool[i] = $random(seed);
    end
    wait (!reset_i);
    wait_cycles(5);

    write_xfer(StaticAddr, 7, 1'b1);
    expect_words(last_base, 7);
    check_rx(make_desc(7, 0, 0, 0, 0));

    write_xfer(DynAddr, 2, 1'b1);
    expect_words(last_base, 2);
    check_rx(make_desc(2, 0, 0, 1, 0));

    write_xfer(i3c_target_pkg::I3C_BCAST_ADDR, 2, 1'b1);
    expect_words(last_base, 2);
    check_rx(make_desc(2, 0, 0, 0, 0));

    write_xfer(7'h33, 2, 1'b0);
    check_quiet();

    enable_i = 1'b0;
    write_xfer(StaticAddr, 2, 1'b0);
    check_quiet();
    enable_i = 1'b1;

    tx_words.push_back({pool[60], pool[61], pool[62], pool[63]});
    tx_words.push_back({pool[56], pool[57], pool[58], pool[59]});
    read_xfer(StaticAddr);
    check_rx(make_desc(read_count, 0, 0, 0, 1));
    check_value("read byte count", read_count, 8);

    bad_tbit = 1;
    write_xfer(StaticAddr, 3, 1'b1);
    bad_tbit = -1;
    expect_words(last_base, 3);
    check_rx(make_desc(3, 1, 0, 0, 0));

    // Two words with the RX queue stalled so bytes after the fifth are lost
    hold_wready = 1'b1;
    write_xfer(StaticAddr, 8, 1'b1);
    wait_cycles(20);
    hold_wready = 1'b0;
    expect_words(last_base, 5);
    check_rx(make_desc(5, 0, 1, 0, 0));

    wait_cycles(10);
    $display("errors: %0d value, %0d protocol, %0d timeout",
             value_errors, proto_errors, timeout_errors);
    if (value_errors + proto_errors + timeout_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("watchdog expired before all transfers finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/bus_monitor.sv
// Bus condition detector, synchronizes SCL/SDA and emits START, STOP and SCL edge pulses
`timescale 1ns/1ps
`default_nettype none

module bus_monitor (
  input  logic clk_i,
  input  logic reset_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic start_det_o,
  output logic stop_det_o,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic sda_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_q;
  logic       sda_q;
  logic       scl_now;
  logic       sda_now;

  assign scl_now = scl_sync_q[1];
  assign sda_now = sda_sync_q[1];

  // Idle bus is high on both lines
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      scl_sync_q  <= 2'b11;
      sda_sync_q  <= 2'b11;
      scl_q       <= 1'b1;
      sda_q       <= 1'b1;
      start_det_o <= 1'b0;
      stop_det_o  <= 1'b0;
      scl_rise_o  <= 1'b0;
      scl_fall_o  <= 1'b0;
    end else begin
      scl_sync_q  <= {scl_sync_q[0], scl_i};
      sda_sync_q  <= {sda_sync_q[0], sda_i};
      scl_q       <= scl_now;
      sda_q       <= sda_now;
      // SDA moves while SCL stays high
      start_det_o <= scl_q && scl_now && sda_q && !sda_now;
      stop_det_o  <= scl_q && scl_now && !sda_q && sda_now;
      scl_rise_o  <= !scl_q && scl_now;
      scl_fall_o  <= scl_q && !scl_now;
    end
  end

  // Level aligned with the edge pulses
  assign sda_o = sda_q;

  start_stop_exclusive_a : assert property (
    @(posedge clk_i) disable iff (reset_i) !(start_det_o && stop_det_o)
  );

endmodule

`default_nettype wire

//--- hdl/controller_standby_i3c.sv
// Top level of the I3C standby target, set addresses and queue width through its parameters
`timescale 1ns/1ps
`default_nettype none

module controller_standby_i3c #(
  parameter logic [6:0]  StaticAddr = 7'h22,
  parameter logic [6:0]  DynAddr    = 7'h5A,
  parameter int unsigned QueueWidth = 32
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  enable_i,

  // SDA/SCL pins, SCL is never driven
  input  logic                                  scl_i,
  input  logic                                  sda_i,
  output logic                                  sda_o,

  // RX data queue
  output logic                                  rx_queue_wvalid_o,
  input  logic                                  rx_queue_wready_i,
  output logic [QueueWidth-1:0]                 rx_queue_wdata_o,

  // RX descriptor queue
  output logic                                  rx_desc_wvalid_o,
  input  logic                                  rx_desc_wready_i,
  output logic [i3c_target_pkg::DESC_WIDTH-1:0] rx_desc_wdata_o,

  // TX data queue
  input  logic                                  tx_queue_rvalid_i,
  output logic                                  tx_queue_rready_o,
  input  logic [QueueWidth-1:0]                 tx_queue_rdata_i
);

  logic       start_det;
  logic       stop_det;
  logic       scl_rise;
  logic       scl_fall;
  logic       sda_sync;
  logic       rx_byte_valid;
  logic       rx_byte_ready;
  logic [7:0] rx_byte;
  logic       tx_byte_valid;
  logic       tx_byte_ready;
  logic [7:0] tx_byte;
  logic       xfer_begin;
  logic       xfer_read;
  logic       dyn_hit;
  logic       xfer_end;
  logic       parity_err;
  logic       overflow;

  bus_monitor xbus_monitor (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .start_det_o(start_det),
    .stop_det_o (stop_det),
    .scl_rise_o (scl_rise),
    .scl_fall_o (scl_fall),
    .sda_o      (sda_sync)
  );

  i3c_target_fsm #(
    .StaticAddr(StaticAddr),
    .DynAddr   (DynAddr)
  ) xi3c_target_fsm (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .enable_i       (enable_i),
    .start_det_i    (start_det),
    .stop_det_i     (stop_det),
    .scl_rise_i     (scl_rise),
    .scl_fall_i     (scl_fall),
    .sda_i          (sda_sync),
    .rx_byte_ready_i(rx_byte_ready),
    .tx_byte_valid_i(tx_byte_valid),
    .tx_byte_i      (tx_byte),
    .sda_o          (sda_o),
    .rx_byte_valid_o(rx_byte_valid),
    .rx_byte_o      (rx_byte),
    .tx_byte_ready_o(tx_byte_ready),
    .xfer_begin_o   (xfer_begin),
    .xfer_read_o    (xfer_read),
    .dyn_hit_o      (dyn_hit),
    .xfer_end_o     (xfer_end),
    .parity_err_o   (parity_err),
    .overflow_o     (overflow)
  );

  target_queue_flow #(
    .QueueWidth(QueueWidth)
  ) xtarget_queue_flow (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .rx_byte_valid_i  (rx_byte_valid),
    .rx_byte_i        (rx_byte),
    .tx_byte_ready_i  (tx_byte_ready),
    .xfer_begin_i     (xfer_begin),
    .xfer_read_i      (xfer_read),
    .dyn_hit_i        (dyn_hit),
    .xfer_end_i       (xfer_end),
    .parity_err_i     (parity_err),
    .overflow_i       (overflow),
    .rx_queue_wready_i(rx_queue_wready_i),
    .rx_desc_wready_i (rx_desc_wready_i),
    .tx_queue_rvalid_i(tx_queue_rvalid_i),
    .tx_queue_rdata_i (tx_queue_rdata_i),
    .rx_byte_ready_o  (rx_byte_ready),
    .tx_byte_valid_o  (tx_byte_valid),
    .tx_byte_o        (tx_byte),
    .rx_queue_wvalid_o(rx_queue_wvalid_o),
    .rx_queue_wdata_o (rx_queue_wdata_o),
    .rx_desc_wvalid_o (rx_desc_wvalid_o),
    .rx_desc_wdata_o  (rx_desc_wdata_o),
    .tx_queue_rready_o(tx_queue_rready_o)
  );

endmodule

`default_nettype wire

//--- hdl/i3c_target_fsm.sv
// Bit-level I3C target engine, matches the header, ACKs, receives and sends bytes with T-bits
`timescale 1ns/1ps
`default_nettype none

module i3c_target_fsm #(
  parameter logic [6:0] StaticAddr = 7'h22,
  parameter logic [6:0] DynAddr    = 7'h5A
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       enable_i,
  input  logic       start_det_i,
  input  logic       stop_det_i,
  input  logic       scl_rise_i,
  input  logic       scl_fall_i,
  input  logic       sda_i,
  input  logic       rx_byte_ready_i,
  input  logic       tx_byte_valid_i,
  input  logic [7:0] tx_byte_i,
  output logic       sda_o,
  output logic       rx_byte_valid_o,
  output logic [7:0] rx_byte_o,
  output logic       tx_byte_ready_o,
  output logic       xfer_begin_o,
  output logic       xfer_read_o,
  output logic       dyn_hit_o,
  output logic       xfer_end_o,
  output logic       parity_err_o,
  output logic       overflow_o
);

  i3c_target_pkg::target_state_e  state_q;
  i3c_target_pkg::transfer_type_e xfer_type_q;

  logic [2:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic       have_byte_q;
  logic       active_q;
  logic [7:0] shift_in;
  logic [7:0] tx_next;
  logic       sta_match;
  logic       dyn_match;
  logic       bc_match;

  assign shift_in = {shift_q[6:0], sda_i};

  // Header is complete at the 8th rise, RnW in bit 0
  assign sta_match = shift_in[7:1] == StaticAddr;
  assign dyn_match = shift_in[7:1] == DynAddr;
  assign bc_match  = (shift_in[7:1] == i3c_target_pkg::I3C_BCAST_ADDR) && !shift_in[0];

  // Nothing to send reads as all ones
  assign tx_next = tx_byte_valid_i ? tx_byte_i : 8'hFF;

  // bit_cnt_q[0] marks the SCL rise of the ACK or T-bit slot
  assign tx_byte_ready_o = scl_fall_i && bit_cnt_q[0] && !start_det_i && !stop_det_i &&
      ((state_q == i3c_target_pkg::st_addr_ack &&
        xfer_type_q == i3c_target_pkg::type_read) ||
       (state_q == i3c_target_pkg::st_rd_tbit && sda_o));

  assign xfer_read_o = xfer_type_q == i3c_target_pkg::type_read;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q         <= i3c_target_pkg::st_idle;
      xfer_type_q     <= i3c_target_pkg::type_write;
      bit_cnt_q       <= '0;
      have_byte_q     <= 1'b0;
      active_q        <= 1'b0;
      sda_o           <= 1'b1;
      rx_byte_valid_o <= 1'b0;
      xfer_begin_o    <= 1'b0;
      xfer_end_o      <= 1'b0;
      dyn_hit_o       <= 1'b0;
      parity_err_o    <= 1'b0;
      overflow_o      <= 1'b0;
    end else begin
      xfer_begin_o <= 1'b0;
      xfer_end_o   <= 1'b0;
      if (rx_byte_valid_o && rx_byte_ready_i) begin
        rx_byte_valid_o <= 1'b0;
      end

      if (start_det_i || stop_det_i) begin
        xfer_end_o <= active_q;
        active_q   <= 1'b0;
        sda_o      <= 1'b1;
        bit_cnt_q  <= '0;
        state_q    <= (start_det_i && enable_i) ? i3c_target_pkg::st_addr
                                                : i3c_target_pkg::st_idle;
      end else begin
        case (state_q)
          i3c_target_pkg::st_addr: begin
            if (scl_rise_i) begin
              shift_q   <= shift_in;
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                xfer_type_q <= shift_in[0] ? i3c_target_pkg::type_read
                                           : i3c_target_pkg::type_write;
                dyn_hit_o   <= dyn_match;
                state_q     <= (sta_match || dyn_match || bc_match) ?
                               i3c_target_pkg::st_addr_ack : i3c_target_pkg::st_wait_stop;
              end
            end
          end

          i3c_target_pkg::st_addr_ack: begin
            if (scl_fall_i && !bit_cnt_q[0]) begin
              sda_o <= 1'b0;
            end else if (scl_rise_i) begin
              bit_cnt_q    <= 3'd1;
              xfer_begin_o <= 1'b1;
              active_q     <= 1'b1;
              parity_err_o <= 1'b0;
              overflow_o   <= 1'b0;
            end else if (scl_fall_i && xfer_type_q == i3c_target_pkg::type_write) begin
              sda_o     <= 1'b1;
              bit_cnt_q <= '0;
              state_q   <= i3c_target_pkg::st_wr_data;
            end
          end

          i3c_target_pkg::st_wr_data: begin
            if (scl_rise_i) begin
              shift_q   <= shift_in;
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                state_q <= i3c_target_pkg::st_wr_tbit;
                // Previous byte still waiting, this one is lost
                if (rx_byte_valid_o && !rx_byte_ready_i) begin
                  overflow_o <= 1'b1;
                end else begin
                  rx_byte_o       <= shift_in;
                  rx_byte_valid_o <= 1'b1;
                end
              end
            end
          end

          i3c_target_pkg::st_wr_tbit: begin
            if (scl_rise_i) begin
              // Odd parity over data and T-bit
              if (!(^{shift_q, sda_i})) begin
                parity_err_o <= 1'b1;
              end
              state_q <= i3c_target_pkg::st_wr_data;
            end
          end

          i3c_target_pkg::st_rd_data: begin
            if (scl_fall_i) begin
              sda_o   <= shift_q[7];
              shift_q <= {shift_q[6:0], 1'b1};
            end
            if (scl_rise_i) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                state_q <= i3c_target_pkg::st_rd_tbit;
              end
            end
          end

          i3c_target_pkg::st_rd_tbit: begin
            if (scl_fall_i && !bit_cnt_q[0]) begin
              // End-of-data flag, 1 only if another byte is ready
              sda_o <= have_byte_q && tx_byte_valid_i;
            end else if (scl_rise_i) begin
              bit_cnt_q <= 3'd1;
            end else if (scl_fall_i && !sda_o) begin
              sda_o   <= 1'b1;
              state_q <= i3c_target_pkg::st_wait_stop;
            end
          end

          default: begin
          end
        endcase

        // Byte load at the fall after ACK or a T-bit of 1
        if (tx_byte_ready_o) begin
          sda_o       <= tx_next[7];
          shift_q     <= {tx_next[6:0], 1'b1};
          have_byte_q <= tx_byte_valid_i;
          bit_cnt_q   <= '0;
          state_q     <= i3c_target_pkg::st_rd_data;
        end
      end
    end
  end

  sda_drive_states_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    !sda_o |-> state_q inside {i3c_target_pkg::st_addr_ack,
                               i3c_target_pkg::st_rd_data,
                               i3c_target_pkg::st_rd_tbit}
  );

  rx_byte_hold_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    rx_byte_valid_o && !rx_byte_ready_i |=> rx_byte_valid_o && $stable(rx_byte_o)
  );

endmodule

`default_nettype wire

//--- hdl/i3c_target_pkg.sv
// Shared FSM types and RX descriptor layout for the I3C standby target, referenced by scoped names
`default_nettype none

package i3c_target_pkg;

  // Target protocol engine states
  typedef enum logic [2:0] {
    st_idle,
    st_addr,
    st_addr_ack,
    st_wr_data,
    st_wr_tbit,
    st_rd_data,
    st_rd_tbit,
    st_wait_stop
  } target_state_e;

  // Direction taken from the RnW bit of the header
  typedef enum logic {
    type_write = 1'b0,
    type_read  = 1'b1
  } transfer_type_e;

  localparam logic [6:0] I3C_BCAST_ADDR = 7'h7E;

  // RX descriptor layout, unlisted bits are zero
  localparam int unsigned DESC_WIDTH = 32;
  localparam int unsigned DESC_COUNT_W = 16;
  localparam int unsigned DESC_COUNT_LSB = 0;
  localparam int unsigned DESC_PARITY_ERR_BIT = 16;
  localparam int unsigned DESC_OVERFLOW_BIT = 17;
  localparam int unsigned DESC_DYN_HIT_BIT = 18;
  localparam int unsigned DESC_READ_BIT = 19;

endpackage

`default_nettype wire

//--- hdl/target_queue_flow.sv
// Queue side of the target, packs RX bytes into words plus one descriptor and unpacks TX words
`timescale 1ns/1ps
`default_nettype none

module target_queue_flow #(
  parameter int unsigned QueueWidth = 32
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  rx_byte_valid_i,
  input  logic [7:0]                            rx_byte_i,
  input  logic                                  tx_byte_ready_i,
  input  logic                                  xfer_begin_i,
  input  logic                                  xfer_read_i,
  input  logic                                  dyn_hit_i,
  input  logic                                  xfer_end_i,
  input  logic                                  parity_err_i,
  input  logic                                  overflow_i,
  input  logic                                  rx_queue_wready_i,
  input  logic                                  rx_desc_wready_i,
  input  logic                                  tx_queue_rvalid_i,
  input  logic [QueueWidth-1:0]                 tx_queue_rdata_i,
  output logic                                  rx_byte_ready_o,
  output logic                                  tx_byte_valid_o,
  output logic [7:0]                            tx_byte_o,
  output logic                                  rx_queue_wvalid_o,
  output logic [QueueWidth-1:0]                 rx_queue_wdata_o,
  output logic                                  rx_desc_wvalid_o,
  output logic [i3c_target_pkg::DESC_WIDTH-1:0] rx_desc_wdata_o,
  output logic                                  tx_queue_rready_o
);

  localparam int unsigned BytesPerWord = QueueWidth / 8;
  localparam int unsigned IdxW = (BytesPerWord > 1) ? $clog2(BytesPerWord) : 1;
  localparam logic [IdxW-1:0] LastIdx = IdxW'(BytesPerWord - 1);

  logic [IdxW-1:0]                         rx_idx_q;
  logic [IdxW-1:0]                         tx_idx_q;
  logic [QueueWidth-1:0]                   rx_word_q;
  logic [QueueWidth-1:0]                   tx_word_q;
  logic                                    rx_word_valid_q;
  logic                                    end_pend_q;
  logic                                    desc_wait_q;
  logic                                    desc_valid_q;
  logic                                    rd_active_q;
  logic                                    tx_have_q;
  logic [i3c_target_pkg::DESC_COUNT_W-1:0] byte_cnt_q;
  logic                                    end_read_q;
  logic                                    end_dyn_q;
  logic                                    end_parity_q;
  logic                                    end_overflow_q;
  logic [i3c_target_pkg::DESC_WIDTH-1:0]   desc_q;
  logic [i3c_target_pkg::DESC_WIDTH-1:0]   desc_next;
  logic                                    rx_accept;
  logic                                    tx_accept;
  logic                                    flush_go;

  // Byte input pauses while a word or the descriptor is outstanding
  assign rx_byte_ready_o = !rx_word_valid_q && !desc_wait_q && !desc_valid_q;
  assign rx_accept       = rx_byte_valid_i && rx_byte_ready_o;
  assign tx_accept       = tx_byte_valid_o && tx_byte_ready_i;

  // Wait for any last byte still in flight before closing the transfer
  assign flush_go = (xfer_end_i || end_pend_q) && !rx_word_valid_q && !rx_byte_valid_i &&
                    !desc_wait_q && !desc_valid_q;

  assign rx_queue_wvalid_o = rx_word_valid_q;
  assign rx_queue_wdata_o  = rx_word_q;
  assign rx_desc_wvalid_o  = desc_valid_q;
  assign rx_desc_wdata_o   = desc_q;

  assign tx_queue_rready_o = rd_active_q && !tx_have_q;
  assign tx_byte_valid_o   = tx_have_q;
  assign tx_byte_o         = tx_word_q[8*tx_idx_q +: 8];

  always_comb begin
    desc_next = '0;
    desc_next[i3c_target_pkg::DESC_COUNT_LSB +: i3c_target_pkg::DESC_COUNT_W] = byte_cnt_q;
    desc_next[i3c_target_pkg::DESC_PARITY_ERR_BIT] = end_parity_q;
    desc_next[i3c_target_pkg::DESC_OVERFLOW_BIT]   = end_overflow_q;
    desc_next[i3c_target_pkg::DESC_DYN_HIT_BIT]    = end_dyn_q;
    desc_next[i3c_target_pkg::DESC_READ_BIT]       = end_read_q;
  end

  // Little-endian packing, a new word starts zeroed
  always_ff @(posedge clk_i) begin
    if (rx_accept) begin
      if (rx_idx_q == '0) begin
        rx_word_q <= QueueWidth'(rx_byte_i);
      end else begin
        rx_word_q[8*rx_idx_q +: 8] <= rx_byte_i;
      end
    end
    if (tx_queue_rvalid_i && tx_queue_rready_o) begin
      tx_word_q <= tx_queue_rdata_i;
    end
    if (desc_wait_q && !rx_word_valid_q) begin
      desc_q <= desc_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_idx_q        <= '0;
      tx_idx_q        <= '0;
      rx_word_valid_q <= 1'b0;
      end_pend_q      <= 1'b0;
      desc_wait_q     <= 1'b0;
      desc_valid_q    <= 1'b0;
      rd_active_q     <= 1'b0;
      tx_have_q       <= 1'b0;
      byte_cnt_q      <= '0;
      end_read_q      <= 1'b0;
      end_dyn_q       <= 1'b0;
      end_parity_q    <= 1'b0;
      end_overflow_q  <= 1'b0;
    end else begin
      if (rx_accept) begin
        rx_idx_q <= (rx_idx_q == LastIdx) ? '0 : rx_idx_q + 1'b1;
        if (rx_idx_q == LastIdx) begin
          rx_word_valid_q <= 1'b1;
        end
      end
      if (rx_word_valid_q && rx_queue_wready_i) begin
        rx_word_valid_q <= 1'b0;
      end
      if (rx_accept || tx_accept) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
      end

      if (xfer_begin_i) begin
        rd_active_q <= xfer_read_i;
      end

      if (tx_queue_rvalid_i && tx_queue_rready_o) begin
        tx_have_q <= 1'b1;
        tx_idx_q  <= '0;
      end
      if (tx_accept) begin
        if (tx_idx_q == LastIdx) begin
          tx_have_q <= 1'b0;
        end else begin
          tx_idx_q <= tx_idx_q + 1'b1;
        end
      end

      // Unsent TX bytes are dropped here
      if (xfer_end_i) begin
        end_pend_q     <= 1'b1;
        end_read_q     <= xfer_read_i;
        end_dyn_q      <= dyn_hit_i;
        end_parity_q   <= parity_err_i;
        end_overflow_q <= overflow_i;
        rd_active_q    <= 1'b0;
        tx_have_q      <= 1'b0;
      end

      if (flush_go) begin
        end_pend_q  <= 1'b0;
        desc_wait_q <= 1'b1;
        if (rx_idx_q != '0) begin
          rx_word_valid_q <= 1'b1;
          rx_idx_q        <= '0;
        end
      end

      if (desc_wait_q && !rx_word_valid_q) begin
        desc_wait_q  <= 1'b0;
        desc_valid_q <= 1'b1;
        byte_cnt_q   <= '0;
      end
      if (desc_valid_q && rx_desc_wready_i) begin
        desc_valid_q <= 1'b0;
      end
    end
  end

  desc_after_data_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    rx_desc_wvalid_o && rx_desc_wready_i |-> !rx_queue_wvalid_o
  );

endmodule

`default_nettype wire

//--- sim.f
hdl/i3c_target_pkg.sv
hdl/bus_monitor.sv
hdl/i3c_target_fsm.sv
hdl/target_queue_flow.sv
hdl/controller_standby_i3c.sv
bench/clk_rst_gen.sv
bench/tb_controller_standby_i3c.sv
